//--- ooo_settings.svh
`ifndef OOO_SETTINGS_SVH
`define OOO_SETTINGS_SVH

// data path
`define XLEN        32

// register file and rename
`define ARCH_REGS   32
`define PHYS_REGS   64

// window sizes
`define ROB_DEPTH   16
`define RS_DEPTH    4

// multiplier stages
`define MUL_LATENCY 3

`endif

//--- ooo_pkg.sv
`default_nettype none

`include "ooo_settings.svh"

package ooo_pkg;

    typedef logic [`XLEN-1:0]               word_t;
    typedef logic [$clog2(`ARCH_REGS)-1:0]  arch_reg_t;
    typedef logic [$clog2(`PHYS_REGS)-1:0]  phys_tag_t;
    typedef logic [$clog2(`ROB_DEPTH)-1:0]  rob_idx_t;

    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_slt,
        op_sll,
        op_srl,
        op_mul
    } alu_op_e;

    typedef enum logic [1:0] {
        unit_alu,
        unit_mul,
        unit_none   // completes at dispatch, writes nothing
    } unit_e;

    typedef struct packed {
        unit_e     unit;
        alu_op_e   op;
        arch_reg_t rs1;
        arch_reg_t rs2;
        arch_reg_t rd;
        logic      use_imm;
        word_t     imm;     // already sign extended
    } decoded_t;

    typedef struct packed {
        phys_tag_t tag;
        logic      ready;
        word_t     value;
    } operand_t;

    typedef struct packed {
        alu_op_e   op;
        phys_tag_t dst_tag;
        rob_idx_t  rob_idx;
        operand_t  src1;
        operand_t  src2;    // holds the immediate for I-type
    } issue_t;

    typedef struct packed {
        logic      valid;
        phys_tag_t tag;
        rob_idx_t  rob;
        word_t     value;
    } result_t;

    typedef struct packed {
        logic      valid;
        arch_reg_t rd;
        word_t     value;
    } commit_t;

endpackage

`default_nettype wire

//--- inst_decoder.sv
`default_nettype none

module inst_decoder import ooo_pkg::*; (
    input  wire word_t inst,
    output decoded_t   dec
);
    logic [6:0] opcode;
    logic [6:0] funct7;
    logic [2:0] funct3;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        dec.unit    = unit_none;
        dec.op      = op_add;
        dec.rs1     = inst[19:15];
        dec.rs2     = inst[24:20];
        dec.rd      = inst[11:7];
        dec.use_imm = 1'b0;
        dec.imm     = {{20{inst[31]}}, inst[31:20]};
        case (opcode)
            7'b0110011: begin
                dec.unit = unit_alu;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: dec.op = op_add;
                    {7'h20, 3'b000}: dec.op = op_sub;
                    {7'h00, 3'b111}: dec.op = op_and;
                    {7'h00, 3'b110}: dec.op = op_or;
                    {7'h00, 3'b100}: dec.op = op_xor;
                    {7'h00, 3'b010}: dec.op = op_slt;
                    {7'h00, 3'b001}: dec.op = op_sll;
                    {7'h00, 3'b101}: dec.op = op_srl;
                    {7'h01, 3'b000}: begin
                        dec.op   = op_mul;
                        dec.unit = unit_mul;
                    end
                    default: dec.unit = unit_none;
                endcase
            end
            7'b0010011: begin
                dec.unit    = unit_alu;
                dec.use_imm = 1'b1;
                case (funct3)
                    3'b000:  dec.op = op_add;
                    3'b111:  dec.op = op_and;
                    3'b110:  dec.op = op_or;
                    3'b100:  dec.op = op_xor;
                    default: dec.unit = unit_none;   // slti, shifts by imm etc
                endcase
            end
            default: dec.unit = unit_none;
        endcase
        if (dec.rd == '0)
            dec.unit = unit_none;
        if (dec.unit == unit_none)
            dec.rd = '0;     // commits as a write to x0
    end

endmodule

`default_nettype wire

//--- rename_unit.sv
`default_nettype none

`include "ooo_settings.svh"

module rename_unit import ooo_pkg::*; (
    input  wire            clk,
    input  wire            rst_n,
    input  wire            dispatch,
    input  wire decoded_t  dec,
    output phys_tag_t      src1_tag,
    output phys_tag_t      src2_tag,
    output phys_tag_t      dst_tag,
    output phys_tag_t      old_tag,
    output logic           free_empty,
    input  wire            free_valid,
    input  wire phys_tag_t free_tag
);
    localparam int FREE_DEPTH = `PHYS_REGS - `ARCH_REGS;
    localparam int PW         = $clog2(FREE_DEPTH);

    phys_tag_t     rat [`ARCH_REGS];
    phys_tag_t     free_q [FREE_DEPTH];
    logic [PW-1:0] rd_ptr;
    logic [PW-1:0] wr_ptr;
    logic [PW:0]   count;
    logic          pop;

    assign pop        = dispatch && (dec.unit != unit_none);
    assign src1_tag   = rat[dec.rs1];
    assign src2_tag   = rat[dec.rs2];
    assign old_tag    = rat[dec.rd];
    assign dst_tag    = free_q[rd_ptr];    // head of the free list
    assign free_empty = (count == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                rat[i] <= phys_tag_t'(i);
            end
            for (int i = 0; i < FREE_DEPTH; i++) begin
                free_q[i] <= phys_tag_t'(`ARCH_REGS + i);
            end
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= (PW+1)'(FREE_DEPTH);
        end else begin
            if (pop) begin
                rat[dec.rd] <= dst_tag;
                rd_ptr      <= rd_ptr + 1'b1;
            end
            if (free_valid) begin
                free_q[wr_ptr] <= free_tag;
                wr_ptr         <= wr_ptr + 1'b1;
            end
            count <= count + (PW+1)'(free_valid) - (PW+1)'(pop);
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) pop |-> !free_empty)
        else $error("rename: pop from empty free list");
    assert property (@(posedge clk) disable iff (!rst_n)
        free_valid |-> count != (PW+1)'(FREE_DEPTH))
        else $error("rename: push into full free list");

endmodule

`default_nettype wire

//--- phys_reg_file.sv
`default_nettype none

`include "ooo_settings.svh"

module phys_reg_file import ooo_pkg::*; (
    input  wire            clk,
    input  wire            rst_n,
    input  wire            dispatch,
    input  wire phys_tag_t dst_tag,
    input  wire phys_tag_t src1_tag,
    input  wire phys_tag_t src2_tag,
    input  wire result_t   alu_result,
    input  wire result_t   mul_result,
    output word_t          src1_value,
    output word_t          src2_value,
    output logic           src1_ready,
    output logic           src2_ready
);
    word_t                 regs [`PHYS_REGS];
    logic [`PHYS_REGS-1:0] ready;

    // {ready, value}, same cycle writes forwarded
    function automatic logic [`XLEN:0] read_port(phys_tag_t tag);
        if (tag == '0)
            return {1'b1, word_t'(0)};
        if (alu_result.valid && alu_result.tag == tag)
            return {1'b1, alu_result.value};
        if (mul_result.valid && mul_result.tag == tag)
            return {1'b1, mul_result.value};
        return {ready[tag], regs[tag]};
    endfunction

    always_comb begin
        {src1_ready, src1_value} = read_port(src1_tag);
        {src2_ready, src2_value} = read_port(src2_tag);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `PHYS_REGS; i++) begin
                regs[i]  <= '0;
                ready[i] <= (i < `ARCH_REGS);
            end
        end else begin
            if (dispatch)
                ready[dst_tag] <= 1'b0;     // new destination pending
            if (alu_result.valid) begin
                regs[alu_result.tag]  <= alu_result.value;
                ready[alu_result.tag] <= 1'b1;
            end
            if (mul_result.valid) begin
                regs[mul_result.tag]  <= mul_result.value;
                ready[mul_result.tag] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- reservation_station.sv
`default_nettype none

`include "ooo_settings.svh"

module reservation_station import ooo_pkg::*; #(
    parameter int DEPTH = `RS_DEPTH
) (
    input  wire          clk,
    input  wire          rst_n,
    input  wire          dispatch,
    input  wire issue_t  entry,
    input  wire result_t alu_result,
    input  wire result_t mul_result,
    output logic         full,
    output issue_t       issue,
    output logic         issue_valid
);
    localparam int IW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    issue_t           slot_q [DEPTH];
    logic [DEPTH-1:0] busy_q;
    logic [IW-1:0]    free_idx;
    logic [IW-1:0]    issue_idx;

    function automatic operand_t wake(operand_t src);
        if (!src.ready && alu_result.valid && alu_result.tag == src.tag)
            return '{tag: src.tag, ready: 1'b1, value: alu_result.value};
        if (!src.ready && mul_result.valid && mul_result.tag == src.tag)
            return '{tag: src.tag, ready: 1'b1, value: mul_result.value};
        return src;
    endfunction

    assign full  = &busy_q;
    assign issue = slot_q[issue_idx];

    // lowest free slot and lowest ready slot
    always_comb begin
        free_idx    = '0;
        issue_idx   = '0;
        issue_valid = 1'b0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!busy_q[i])
                free_idx = IW'(i);
            if (busy_q[i] && slot_q[i].src1.ready && slot_q[i].src2.ready) begin
                issue_idx   = IW'(i);
                issue_valid = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= '0;
        end else begin
            if (issue_valid)
                busy_q[issue_idx] <= 1'b0;
            if (dispatch)
                busy_q[free_idx] <= 1'b1;   // never the issuing slot
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            slot_q[i].src1 <= wake(slot_q[i].src1);
            slot_q[i].src2 <= wake(slot_q[i].src2);
        end
        if (dispatch)
            slot_q[free_idx] <= entry;
    end

    assert property (@(posedge clk) disable iff (!rst_n) dispatch |-> !full)
        else $error("rs: dispatch into full station");

endmodule

`default_nettype wire

//--- alu_unit.sv
`default_nettype none

module alu_unit import ooo_pkg::*; (
    input  wire         clk,
    input  wire         rst_n,
    input  wire issue_t op,
    input  wire         op_valid,
    output result_t     result
);
    word_t a;
    word_t b;
    word_t y;

    assign a = op.src1.value;
    assign b = op.src2.value;   // register or immediate

    always_comb begin
        case (op.op)
            op_add:  y = a + b;
            op_sub:  y = a - b;
            op_and:  y = a & b;
            op_or:   y = a | b;
            op_xor:  y = a ^ b;
            op_slt:  y = word_t'($signed(a) < $signed(b));
            op_sll:  y = a << b[4:0];
            op_srl:  y = a >> b[4:0];
            default: y = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            result <= '0;
        else
            result <= '{valid: op_valid, tag: op.dst_tag, rob: op.rob_idx, value: y};
    end

endmodule

`default_nettype wire

//--- mul_pipe.sv
`default_nettype none

`include "ooo_settings.svh"

module mul_pipe import ooo_pkg::*; (
    input  wire         clk,
    input  wire         rst_n,
    input  wire issue_t op,
    input  wire         op_valid,
    output result_t     result
);
    localparam int L = `MUL_LATENCY;

    logic [L-1:0] vld_q;
    phys_tag_t    tag_q [L];
    rob_idx_t     rob_q [L];
    word_t        prod_q [L];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= op_valid;
            for (int i = 1; i < L; i++) begin
                vld_q[i] <= vld_q[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        tag_q[0]  <= op.dst_tag;
        rob_q[0]  <= op.rob_idx;
        prod_q[0] <= op.src1.value * op.src2.value;   // low word only
        for (int i = 1; i < L; i++) begin
            tag_q[i]  <= tag_q[i-1];
            rob_q[i]  <= rob_q[i-1];
            prod_q[i] <= prod_q[i-1];
        end
    end

    assign result = '{valid: vld_q[L-1], tag: tag_q[L-1], rob: rob_q[L-1], value: prod_q[L-1]};

    assert property (@(posedge clk) disable iff (!rst_n) result.valid |-> $past(op_valid, L))
        else $error("mul: result without matching issue");

endmodule

`default_nettype wire

//--- reorder_buffer.sv
`default_nettype none

`include "ooo_settings.svh"

module reorder_buffer import ooo_pkg::*; (
    input  wire            clk,
    input  wire            rst_n,
    input  wire            dispatch,
    input  wire decoded_t  dec,
    input  wire phys_tag_t dst_tag,
    input  wire phys_tag_t old_tag,
    output rob_idx_t       alloc_idx,
    output logic           full,
    input  wire result_t   alu_result,
    input  wire result_t   mul_result,
    output commit_t        commit,
    output logic           free_valid,
    output phys_tag_t      free_tag
);
    localparam int D  = `ROB_DEPTH;
    localparam int CW = $clog2(D) + 1;

    logic [D-1:0]  done_q;
    logic [D-1:0]  has_dst_q;
    arch_reg_t     rd_q [D];
    phys_tag_t     dst_q [D];
    phys_tag_t     old_q [D];
    word_t         value_q [D];
    rob_idx_t      head_q;
    rob_idx_t      tail_q;
    logic [CW-1:0] count_q;
    logic          retire;

    assign alloc_idx = tail_q;
    assign full      = (count_q == CW'(D));
    assign retire    = (count_q != '0) && done_q[head_q];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_q     <= '0;
            has_dst_q  <= '0;
            head_q     <= '0;
            tail_q     <= '0;
            count_q    <= '0;
            commit     <= '0;
            free_valid <= 1'b0;
            free_tag   <= '0;
        end else begin
            if (alu_result.valid)
                done_q[alu_result.rob] <= 1'b1;
            if (mul_result.valid)
                done_q[mul_result.rob] <= 1'b1;
            if (dispatch) begin
                done_q[tail_q]    <= (dec.unit == unit_none);  // nothing to wait for
                has_dst_q[tail_q] <= (dec.unit != unit_none);
                tail_q            <= tail_q + 1'b1;
            end
            if (retire)
                head_q <= head_q + 1'b1;
            commit     <= '{valid: retire, rd: rd_q[head_q], value: value_q[head_q]};
            free_valid <= retire && has_dst_q[head_q];
            free_tag   <= old_q[head_q];
            count_q    <= count_q + CW'(dispatch) - CW'(retire);
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch) begin
            rd_q[tail_q]    <= dec.rd;
            dst_q[tail_q]   <= dst_tag;
            old_q[tail_q]   <= old_tag;
            value_q[tail_q] <= '0;
        end
        if (alu_result.valid)
            value_q[alu_result.rob] <= alu_result.value;
        if (mul_result.valid)
            value_q[mul_result.rob] <= mul_result.value;
    end

    assert property (@(posedge clk) disable iff (!rst_n) dispatch |-> !full)
        else $error("rob: dispatch into full buffer");
    // a result must land on the slot that was renamed to its tag
    assert property (@(posedge clk) disable iff (!rst_n)
        alu_result.valid |-> alu_result.tag == dst_q[alu_result.rob])
        else $error("rob: alu result tag does not match its slot");

endmodule

`default_nettype wire

//--- ooo_core.sv
`default_nettype none

module ooo_core import ooo_pkg::*; (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        inst_valid,
    input  wire word_t inst,
    output logic       dispatch_stall,
    output commit_t    commit
);
    decoded_t  dec;
    phys_tag_t src1_tag;
    phys_tag_t src2_tag;
    phys_tag_t dst_tag;
    phys_tag_t old_tag;
    phys_tag_t free_tag;
    word_t     src1_value;
    word_t     src2_value;
    logic      src1_ready;
    logic      src2_ready;
    logic      free_empty;
    logic      free_valid;
    logic      rob_full;
    logic      rs_alu_full;
    logic      rs_mul_full;
    logic      rs_full;
    logic      dispatch;
    logic      dispatch_dst;
    logic      dispatch_alu;
    logic      dispatch_mul;
    rob_idx_t  alloc_idx;
    issue_t    entry;
    issue_t    alu_issue;
    issue_t    mul_issue;
    logic      alu_issue_valid;
    logic      mul_issue_valid;
    result_t   alu_result;
    result_t   mul_result;

    always_comb begin
        case (dec.unit)
            unit_alu: rs_full = rs_alu_full;
            unit_mul: rs_full = rs_mul_full;
            default:  rs_full = 1'b0;
        endcase
    end

    // the only stall check in the core
    assign dispatch_stall = rob_full || free_empty || rs_full;
    assign dispatch       = inst_valid && !dispatch_stall;
    assign dispatch_dst   = dispatch && (dec.unit != unit_none);
    assign dispatch_alu   = dispatch && (dec.unit == unit_alu);
    assign dispatch_mul   = dispatch && (dec.unit == unit_mul);

    always_comb begin
        entry.op      = dec.op;
        entry.dst_tag = dst_tag;
        entry.rob_idx = alloc_idx;
        entry.src1    = '{tag: src1_tag, ready: src1_ready, value: src1_value};
        if (dec.use_imm)
            entry.src2 = '{tag: '0, ready: 1'b1, value: dec.imm};
        else
            entry.src2 = '{tag: src2_tag, ready: src2_ready, value: src2_value};
    end

    inst_decoder u_decoder (
        .inst (inst),
        .dec  (dec)
    );

    rename_unit u_rename (
        .clk        (clk),
        .rst_n      (rst_n),
        .dispatch   (dispatch),
        .dec        (dec),
        .src1_tag   (src1_tag),
        .src2_tag   (src2_tag),
        .dst_tag    (dst_tag),
        .old_tag    (old_tag),
        .free_empty (free_empty),
        .free_valid (free_valid),
        .free_tag   (free_tag)
    );

    phys_reg_file u_prf (
        .clk        (clk),
        .rst_n      (rst_n),
        .dispatch   (dispatch_dst),
        .dst_tag    (dst_tag),
        .src1_tag   (src1_tag),
        .src2_tag   (src2_tag),
        .alu_result (alu_result),
        .mul_result (mul_result),
        .src1_value (src1_value),
        .src2_value (src2_value),
        .src1_ready (src1_ready),
        .src2_ready (src2_ready)
    );

    reorder_buffer u_rob (
        .clk        (clk),
        .rst_n      (rst_n),
        .dispatch   (dispatch),
        .dec        (dec),
        .dst_tag    (dst_tag),
        .old_tag    (old_tag),
        .alloc_idx  (alloc_idx),
        .full       (rob_full),
        .alu_result (alu_result),
        .mul_result (mul_result),
        .commit     (commit),
        .free_valid (free_valid),
        .free_tag   (free_tag)
    );

    reservation_station u_rs_alu (
        .clk         (clk),
        .rst_n       (rst_n),
        .dispatch    (dispatch_alu),
        .entry       (entry),
        .alu_result  (alu_result),
        .mul_result  (mul_result),
        .full        (rs_alu_full),
        .issue       (alu_issue),
        .issue_valid (alu_issue_valid)
    );

    reservation_station #(.DEPTH(2)) u_rs_mul (
        .clk         (clk),
        .rst_n       (rst_n),
        .dispatch    (dispatch_mul),
        .entry       (entry),
        .alu_result  (alu_result),
        .mul_result  (mul_result),
        .full        (rs_mul_full),
        .issue       (mul_issue),
        .issue_valid (mul_issue_valid)
    );

    alu_unit u_alu (
        .clk      (clk),
        .rst_n    (rst_n),
        .op       (alu_issue),
        .op_valid (alu_issue_valid),
        .result   (alu_result)
    );

    mul_pipe u_mul (
        .clk      (clk),
        .rst_n    (rst_n),
        .op       (mul_issue),
        .op_valid (mul_issue_valid),
        .result   (mul_result)
    );

endmodule

`default_nettype wire

//--- ooo_core_tb.sv
`default_nettype none

`include "ooo_settings.svh"

module ooo_core_tb import ooo_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD  = 100;
    localparam int RESET_CYCLES = 3;
    localparam int N_DIRECTED  = 43;
    localparam int N_RANDOM    = 200;
    localparam int WATCHDOG_NS = (N_DIRECTED + N_RANDOM + RESET_CYCLES)
                                 * (`MUL_LATENCY + `ROB_DEPTH + 4) * CLK_PERIOD;

    logic    clk;
    logic    rst_n;
    logic    inst_valid;
    word_t   inst;
    logic    dispatch_stall;
    commit_t commit;

    word_t   arch_regs [`ARCH_REGS];    // architectural reference state
    commit_t exp_q [$];
    commit_t got_q [$];
    integer  seed = 36955;
    int      error_count;
    int      commit_count;
    logic    stall_seen;

    ooo_core uut (
        .clk            (clk),
        .rst_n          (rst_n),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .dispatch_stall (dispatch_stall),
        .commit         (commit)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // commit is registered, stable at the falling edge
    always @(negedge clk) begin
        if (rst_n && commit.valid)
            got_q.push_back(commit);
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the core did not finish its instructions within %0d ns", WATCHDOG_NS);
        abort_run();
    end

    task automatic abort_run;
        $display("Simulation failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_commit(string name, commit_t got, commit_t exp);
        if (got !== exp) begin
            error_count++;
            $display("ERROR %0d ns: %s got %b/%0d/%h, expected %b/%0d/%h (valid/rd/value)",
                     $time, name, got.valid, got.rd, got.value, exp.valid, exp.rd, exp.value);
            abort_run();
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            error_count++;
            $display("ERROR %0d ns: %s got %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    function automatic word_t encode_rr(alu_op_e op, arch_reg_t rd, arch_reg_t rs1,
                                        arch_reg_t rs2);
        logic [6:0] f7;
        logic [2:0] f3;
        f7 = 7'h00;
        case (op)
            op_add: f3 = 3'b000;
            op_sub: begin
                f7 = 7'h20;
                f3 = 3'b000;
            end
            op_and: f3 = 3'b111;
            op_or:  f3 = 3'b110;
            op_xor: f3 = 3'b100;
            op_slt: f3 = 3'b010;
            op_sll: f3 = 3'b001;
            op_srl: f3 = 3'b101;
            default: begin    // mul, RV32M
                f7 = 7'h01;
                f3 = 3'b000;
            end
        endcase
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t encode_imm(alu_op_e op, arch_reg_t rd, arch_reg_t rs1,
                                         logic [11:0] imm);
        logic [2:0] f3;
        case (op)
            op_and:  f3 = 3'b111;
            op_or:   f3 = 3'b110;
            op_xor:  f3 = 3'b100;
            default: f3 = 3'b000;
        endcase
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic word_t model_op(alu_op_e op, word_t a, word_t b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            op_sll:  return a << b[4:0];
            op_srl:  return a >> b[4:0];
            default: return a * b;     // low word of the product
        endcase
    endfunction

    // x0 destinations commit as rd 0 with a zero value
    task automatic expect_write(arch_reg_t rd, word_t v);
        commit_t c;
        c = '{valid: 1'b1, rd: '0, value: '0};
        if (rd != '0) begin
            arch_regs[rd] = v;
            c = '{valid: 1'b1, rd: rd, value: v};
        end
        exp_q.push_back(c);
    endtask

    // starts and ends on a falling edge
    task automatic send_inst(word_t w);
        logic accepted;
        accepted   = 1'b0;
        inst_valid = 1'b1;
        inst       = w;
        while (!accepted) begin
            #(CLK_PERIOD / 4);
            if (dispatch_stall) begin
                stall_seen = 1'b1;
                @(negedge clk);
            end else begin
                @(posedge clk);
                @(negedge clk);
                accepted = 1'b1;
            end
        end
        inst_valid = 1'b0;
    endtask

    task automatic run_rr(alu_op_e op, arch_reg_t rd, arch_reg_t rs1, arch_reg_t rs2);
        expect_write(rd, model_op(op, arch_regs[rs1], arch_regs[rs2]));
        send_inst(encode_rr(op, rd, rs1, rs2));
    endtask

    task automatic run_imm(alu_op_e op, arch_reg_t rd, arch_reg_t rs1, logic [11:0] imm);
        expect_write(rd, model_op(op, arch_regs[rs1], {{20{imm[11]}}, imm}));
        send_inst(encode_imm(op, rd, rs1, imm));
    endtask

    task automatic run_unsupported(word_t w);
        expect_write('0, '0);
        send_inst(w);
    endtask

    // compares every expected commit in program order
    task automatic drain_commits;
        commit_t got;
        commit_t exp;
        while (exp_q.size() != 0) begin
            while (got_q.size() == 0)
                @(posedge clk);
            got = got_q.pop_front();
            exp = exp_q.pop_front();
            check_commit($sformatf("commit[%0d]", commit_count), got, exp);
            commit_count++;
        end
        @(negedge clk);
    endtask

    task automatic after_reset;
        check_bit("dispatch_stall", dispatch_stall, 1'b0);
        check_bit("commit.valid", commit.valid, 1'b0);
    endtask

    task automatic alu_opcodes;
        run_imm(op_add, 1, 0, 12'd100);
        run_imm(op_add, 2, 0, 12'hff9);    // -7
        run_imm(op_add, 3, 0, 12'd5);
        run_rr(op_add, 4, 1, 2);
        run_rr(op_sub, 5, 2, 1);
        run_rr(op_and, 6, 1, 2);
        run_rr(op_or, 7, 1, 2);
        run_rr(op_xor, 8, 1, 2);
        run_rr(op_slt, 9, 2, 1);           // signed -7 < 100
        run_rr(op_slt, 10, 1, 2);
        run_rr(op_sll, 11, 1, 3);
        run_rr(op_srl, 12, 2, 3);          // logical shift of a negative
        run_imm(op_and, 13, 2, 12'hf0f);
        run_imm(op_or, 14, 1, 12'h800);
        run_imm(op_xor, 15, 1, 12'hfff);
        run_imm(op_add, 16, 2, 12'hffe);
        drain_commits();
    endtask

    task automatic mul_then_dependent;
        run_imm(op_add, 17, 0, 12'd1234);
        run_imm(op_add, 18, 0, 12'hffd);
        run_rr(op_mul, 19, 17, 18);
        run_rr(op_add, 20, 19, 17);        // needs the product
        run_imm(op_add, 21, 0, 12'd11);
        run_imm(op_add, 22, 0, 12'd22);
        run_imm(op_add, 23, 3, 12'd33);
        run_imm(op_add, 24, 1, 12'h7ff);
        drain_commits();
    endtask

    task automatic mul_chain_stall;
        stall_seen = 1'b0;
        run_imm(op_add, 25, 0, 12'd3);
        run_imm(op_add, 26, 0, 12'd2);
        repeat (8)
            run_rr(op_mul, 26, 26, 25);
        drain_commits();
        check_bit("dispatch_stall seen", stall_seen, 1'b1);
    endtask

    task automatic x0_and_unsupported;
        run_imm(op_add, 0, 1, 12'd5);
        run_rr(op_add, 0, 1, 2);
        run_rr(op_mul, 0, 1, 2);
        run_unsupported({12'd7, 5'd1, 3'b010, 5'd27, 7'b0010011});     // slti
        run_unsupported({12'd0, 5'd1, 3'b010, 5'd28, 7'b0000011});     // lw
        run_unsupported({7'h20, 5'd2, 5'd1, 3'b111, 5'd29, 7'b0110011});
        run_rr(op_add, 27, 0, 1);
        run_imm(op_or, 28, 0, 12'h000);
        run_rr(op_sub, 29, 0, 0);
        drain_commits();
    endtask

    task automatic random_mix;
        int          n;
        int          kind;
        arch_reg_t   rd;
        arch_reg_t   rs1;
        arch_reg_t   rs2;
        logic [11:0] imm;
        for (n = 0; n < N_RANDOM; n++) begin
            kind = $unsigned($random(seed)) % 16;
            rd   = arch_reg_t'($unsigned($random(seed)) % 12);  // few regs, many hazards
            rs1  = arch_reg_t'($unsigned($random(seed)) % 12);
            rs2  = arch_reg_t'($unsigned($random(seed)) % 12);
            imm  = $random(seed);
            if (kind < 8)
                run_rr(alu_op_e'(kind), rd, rs1, rs2);
            else if (kind < 11)
                run_rr(op_mul, rd, rs1, rs2);
            else if (kind == 11)
                run_imm(op_add, rd, rs1, imm);
            else if (kind == 12)
                run_imm(op_and, rd, rs1, imm);
            else if (kind == 13)
                run_imm(op_or, rd, rs1, imm);
            else if (kind == 14)
                run_imm(op_xor, rd, rs1, imm);
            else
                run_unsupported({imm, rs1, 3'b010, rd, 7'b0010011});
        end
        drain_commits();
    endtask

    initial begin
        rst_n        = 1'b0;
        inst_valid   = 1'b0;
        inst         = '0;
        error_count  = 0;
        commit_count = 0;
        stall_seen   = 1'b0;
        for (int i = 0; i < `ARCH_REGS; i++)
            arch_regs[i] = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        after_reset();
        alu_opcodes();
        mul_then_dependent();
        mul_chain_stall();
        x0_and_unsupported();
        random_mix();

        // nothing may commit beyond the program
        repeat (`ROB_DEPTH) @(negedge clk);
        check_bit("no extra commit", got_q.size() == 0, 1'b1);

        if (error_count == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+.
ooo_pkg.sv
inst_decoder.sv
rename_unit.sv
phys_reg_file.sv
reservation_station.sv
alu_unit.sv
mul_pipe.sv
reorder_buffer.sv
ooo_core.sv
ooo_core_tb.sv
